/* logic/l1d_cache.sv */
// Top of the 4-way L1 data cache, read port, line fill and store-through
// Busy outputs mirror the conflicting request levels
`default_nettype none

`include "l1d_config.svh"

module l1d_cache
	import l1d_pkg::*;
#(
	parameter int AGE_W = `L1D_AGE_W_DEFAULT
) (
	input wire iCLOCK,
	input wire inRESET,
	input wire flush,
	input wire rd_req,
	input l1d_addr_t rd_addr,
	input wire rd_stall,
	output logic rd_busy,
	output l1d_rd_result_t rd_result,
	input wire fill_req,
	input l1d_fill_t fill,
	output logic fill_busy,
	input wire store_req,
	input l1d_store_t store,
	output logic store_busy
);

	logic hit;
	l1d_way_t hit_way;
	logic [`L1D_WAYS-1:0] wr_en;
	logic [`L1D_INDEX_W-1:0] wr_index;
	logic [`L1D_LINE_BYTES-1:0] wr_byte_en;
	l1d_line_t wr_line;
	l1d_line_t [`L1D_WAYS-1:0] rd_lines;

	assign rd_busy = rd_stall;
	assign fill_busy = store_req;	// Store takes the write port
	assign store_busy = fill_req;

	// Store word copied to every slot, byte enables pick the lanes
	always_comb begin
		if (store_req) begin
			wr_line.words = {(`L1D_LINE_BYTES / 4){store.data}};
		end else begin
			wr_line = fill.line;
		end
	end

	l1d_tag_array #(
		.AGE_W(AGE_W)
	) l1d_tag_array_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.rd_req(rd_req),
		.rd_stall(rd_stall),
		.rd_addr(rd_addr),
		.fill_req(fill_req),
		.fill_addr(fill.addr),
		.store_req(store_req),
		.store_addr(store.addr),
		.store_mask(store.mask),
		.hit(hit),
		.hit_way(hit_way),
		.wr_en(wr_en),
		.wr_index(wr_index),
		.wr_byte_en(wr_byte_en)
	);

	l1d_data_array l1d_data_array_inst (
		.iCLOCK(iCLOCK),
		.wr_en(wr_en),
		.wr_index(wr_index),
		.wr_byte_en(wr_byte_en),
		.wr_line(wr_line),
		.rd_index(rd_addr.index),
		.rd_stall(rd_stall),
		.rd_lines(rd_lines)
	);

	l1d_read_return l1d_read_return_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.rd_req(rd_req),
		.rd_stall(rd_stall),
		.rd_addr(rd_addr),
		.hit(hit),
		.hit_way(hit_way),
		.rd_lines(rd_lines),
		.rd_result(rd_result)
	);

endmodule

`default_nettype wire

/* logic/l1d_config.svh */
// Geometry, address split and status encoding of the L1 data cache
// Included by the package and by every cache module
`ifndef L1D_CONFIG_SVH
`define L1D_CONFIG_SVH

// Geometry
`define L1D_WAYS 4
`define L1D_SETS 16
`define L1D_LINE_BYTES 64

// Address split: tag | index | word select | byte offset
`define L1D_TAG_W 22
`define L1D_INDEX_W 4
`define L1D_WORD_SEL_W 4

// Recency status, 0 is an empty entry
`define L1D_STAT_INVALID 2'd0
`define L1D_STAT_NEWEST 2'd3

// Aging period is 2**width unstalled cycles
`define L1D_AGE_W_DEFAULT 16

`endif

/* logic/l1d_data_array.sv */
// Line storage of all ways with byte-enabled writes
// Every way is read into a register each unstalled cycle, the way choice comes later
`default_nettype none

`include "l1d_config.svh"

module l1d_data_array
	import l1d_pkg::*;
(
	input wire iCLOCK,
	input wire [`L1D_WAYS-1:0] wr_en,
	input wire [`L1D_INDEX_W-1:0] wr_index,
	input wire [`L1D_LINE_BYTES-1:0] wr_byte_en,
	input l1d_line_t wr_line,
	input wire [`L1D_INDEX_W-1:0] rd_index,
	input wire rd_stall,
	output l1d_line_t [`L1D_WAYS-1:0] rd_lines
);

	l1d_line_t mem [`L1D_WAYS][`L1D_SETS];

	// Byte lanes written through the byte view of the line
	always_ff @(posedge iCLOCK) begin
		for (int w = 0; w < `L1D_WAYS; w++) begin
			for (int b = 0; b < `L1D_LINE_BYTES; b++) begin
				if (wr_en[w] && wr_byte_en[b]) begin
					mem[w][wr_index].bytes[b] <= wr_line.bytes[b];
				end
			end
		end
	end

	// Registered read, old contents on a same-cycle write
	always_ff @(posedge iCLOCK) begin
		if (!rd_stall) begin	// Hold line while consumer stalls
			for (int w = 0; w < `L1D_WAYS; w++) begin
				rd_lines[w] <= mem[w][rd_index];
			end
		end
	end

endmodule

`default_nettype wire

/* logic/l1d_pkg.sv */
// Shared types of the L1 data cache
// Imported by the cache modules and by the testbench
`default_nettype none

`include "l1d_config.svh"

package l1d_pkg;

	// Word address split into its cache fields
	typedef struct packed {
		logic [`L1D_TAG_W-1:0] tag;
		logic [`L1D_INDEX_W-1:0] index;
		logic [`L1D_WORD_SEL_W-1:0] word_sel;
		logic [1:0] byte_off;	// Ignored, reads are word wide
	} l1d_addr_t;

	// Whole line, word view for reads and byte view for masked writes
	typedef union packed {
		logic [`L1D_LINE_BYTES/4-1:0][31:0] words;
		logic [`L1D_LINE_BYTES-1:0][7:0] bytes;
	} l1d_line_t;

	typedef struct packed {
		logic [1:0] status;	// 0 invalid, 3 newest
		logic [`L1D_TAG_W-1:0] tag;
	} l1d_tag_entry_t;

	typedef logic [1:0] l1d_way_t;

	typedef struct packed {
		l1d_addr_t addr;
		l1d_line_t line;
	} l1d_fill_t;

	typedef struct packed {
		l1d_addr_t addr;
		logic [3:0] mask;	// Byte lanes of the word
		logic [31:0] data;
	} l1d_store_t;

	typedef struct packed {
		logic valid;
		logic hit;
		logic [31:0] data;	// Zero on a miss
	} l1d_rd_result_t;

endpackage

`default_nettype wire

/* logic/l1d_read_return.sv */
// Second read stage, holds the request info and picks the hit word
`default_nettype none

`include "l1d_config.svh"

module l1d_read_return
	import l1d_pkg::*;
(
	input wire iCLOCK,
	input wire inRESET,
	input wire flush,
	input wire rd_req,
	input wire rd_stall,
	input l1d_addr_t rd_addr,
	input wire hit,
	input l1d_way_t hit_way,
	input l1d_line_t [`L1D_WAYS-1:0] rd_lines,
	output l1d_rd_result_t rd_result
);

	logic req_q;
	logic hit_q;
	l1d_way_t way_q;
	logic [`L1D_WORD_SEL_W-1:0] word_q;
	logic live;
	l1d_line_t sel_line;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			req_q <= 1'b0;
		end else if (flush) begin
			req_q <= 1'b0;	// Pending read is dropped
		end else if (!rd_stall) begin
			req_q <= rd_req;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (!rd_stall) begin	// Same enable as the data registers
			hit_q <= hit;
			way_q <= hit_way;
			word_q <= rd_addr.word_sel;
		end
	end

	assign live = req_q && !rd_stall;	// Hidden while stalled, held for later
	assign sel_line = rd_lines[way_q];
	assign rd_result.valid = live;
	assign rd_result.hit = live && hit_q;
	assign rd_result.data = (live && hit_q) ? sel_line.words[word_q] : 32'h0;

endmodule

`default_nettype wire

/* logic/l1d_tag_array.sv */
// Tags and recency status of all ways with the hit and victim search and the aging timer
// Drives the data array write controls and the hit info of the current read
`default_nettype none

`include "l1d_config.svh"

module l1d_tag_array
	import l1d_pkg::*;
#(
	parameter int AGE_W = `L1D_AGE_W_DEFAULT
) (
	input wire iCLOCK,
	input wire inRESET,
	input wire flush,
	input wire rd_req,
	input wire rd_stall,
	input l1d_addr_t rd_addr,
	input wire fill_req,
	input l1d_addr_t fill_addr,
	input wire store_req,
	input l1d_addr_t store_addr,
	input wire [3:0] store_mask,
	output logic hit,
	output l1d_way_t hit_way,
	output logic [`L1D_WAYS-1:0] wr_en,
	output logic [`L1D_INDEX_W-1:0] wr_index,
	output logic [`L1D_LINE_BYTES-1:0] wr_byte_en
);

	l1d_tag_entry_t tags [`L1D_WAYS][`L1D_SETS];
	logic [AGE_W-1:0] age_cnt;
	logic aging;
	logic st_hit;
	l1d_way_t st_way;
	l1d_way_t fill_way;

	// Lowest way with matching tag and nonzero status
	function automatic logic [2:0] lookup(input logic [`L1D_TAG_W-1:0] tag,
			input logic [`L1D_INDEX_W-1:0] idx);
		logic [2:0] res;
		res = 3'b000;
		for (int w = `L1D_WAYS - 1; w >= 0; w--) begin	// Descending so way 0 wins
			if (tags[w][idx].status != `L1D_STAT_INVALID && tags[w][idx].tag == tag) begin
				res = {1'b1, l1d_way_t'(w)};
			end
		end
		return res;
	endfunction

	// Same tag first then lowest way of status 0 to 2 and last way otherwise
	function automatic l1d_way_t pick_victim(input l1d_addr_t addr);
		l1d_way_t way;
		logic found;
		way = l1d_way_t'(`L1D_WAYS - 1);
		found = 1'b0;
		for (int w = 0; w < `L1D_WAYS; w++) begin
			if (!found && tags[w][addr.index].tag == addr.tag) begin	// Status ignored here
				way = l1d_way_t'(w);
				found = 1'b1;
			end
		end
		for (int s = 0; s < int'(`L1D_STAT_NEWEST); s++) begin
			for (int w = 0; w < `L1D_WAYS; w++) begin
				if (!found && tags[w][addr.index].status == 2'(s)) begin
					way = l1d_way_t'(w);
					found = 1'b1;
				end
			end
		end
		return way;
	endfunction

	assign aging = &age_cnt;	// Last count of the period
	assign {hit, hit_way} = lookup(rd_addr.tag, rd_addr.index);
	assign {st_hit, st_way} = lookup(store_addr.tag, store_addr.index);
	assign fill_way = pick_victim(fill_addr);

	always_comb begin
		for (int w = 0; w < `L1D_WAYS; w++) begin
			wr_en[w] = !flush && ((store_req && st_hit && st_way == l1d_way_t'(w))
				|| (!store_req && fill_req && fill_way == l1d_way_t'(w)));	// Store wins
		end
	end

	assign wr_index = store_req ? store_addr.index : fill_addr.index;
	assign wr_byte_en = store_req
		? {{(`L1D_LINE_BYTES - 4){1'b0}}, store_mask} << {store_addr.word_sel, 2'b00}
		: {`L1D_LINE_BYTES{1'b1}};	// Fill writes the whole line

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			age_cnt <= '0;
			for (int w = 0; w < `L1D_WAYS; w++) begin
				for (int s = 0; s < `L1D_SETS; s++) begin
					tags[w][s] <= '0;
				end
			end
		end else if (flush) begin	// Drop every line and restart aging period
			age_cnt <= '0;
			for (int w = 0; w < `L1D_WAYS; w++) begin
				for (int s = 0; s < `L1D_SETS; s++) begin
					tags[w][s] <= '0;
				end
			end
		end else begin
			if (!rd_stall) begin
				age_cnt <= age_cnt + AGE_W'(1);
			end
			if (store_req) begin
				if (st_hit && tags[st_way][store_addr.index].status != `L1D_STAT_NEWEST) begin
					tags[st_way][store_addr.index].status <=
						tags[st_way][store_addr.index].status + 2'd1;	// Saturating bump
				end
			end else if (fill_req) begin
				tags[fill_way][fill_addr.index] <=
					'{status: `L1D_STAT_NEWEST, tag: fill_addr.tag};
			end else if (!rd_stall) begin
				for (int w = 0; w < `L1D_WAYS; w++) begin
					for (int s = 0; s < `L1D_SETS; s++) begin
						if (rd_req && hit && hit_way == l1d_way_t'(w)
								&& rd_addr.index == `L1D_INDEX_W'(s)) begin
							tags[w][s].status <= `L1D_STAT_NEWEST;	// Read hit refresh
						end else if (aging && tags[w][s].status[1]) begin
							tags[w][s].status <= tags[w][s].status - 2'd1;	// Only 2 and 3 age
						end
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it, exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_l1d_cache -f verilog.f \
	&& ./obj_dir/Vtb_l1d_cache \
	|| { echo "simulation run failed"; exit 1; }

/* sim/tb_l1d_cache.sv */
// Testbench of the L1 data cache where a reference model predicts every read result
// Directed fill, store, eviction, stall and flush steps followed by a long random run
`default_nettype none

`include "l1d_config.svh"

module tb_l1d_cache
	import l1d_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	logic iCLOCK, inRESET, flush, rd_stall;
	logic rd_req, fill_req, store_req;
	logic rd_busy, fill_busy, store_busy;
	l1d_addr_t rd_addr;
	l1d_fill_t fill;
	l1d_store_t store;
	l1d_rd_result_t rd_result;

	integer seed;	// $random state
	logic [1:0] m_stat [`L1D_WAYS][`L1D_SETS];	// Model recency status
	logic [`L1D_TAG_W-1:0] m_tag [`L1D_WAYS][`L1D_SETS];
	logic [31:0] m_data [`L1D_WAYS][`L1D_SETS][`L1D_LINE_BYTES/4];
	logic [5:0] m_age;	// Same width as AGE_W below
	l1d_rd_result_t exp_q;	// Prediction held like the read stage

	l1d_cache #(.AGE_W(6)) l1d_cache_inst (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #2 iCLOCK = ~iCLOCK;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			$display("Test failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Way holding a valid entry of this tag or -1 on a miss
	function automatic int find_way(input l1d_addr_t a);
		for (int w = 0; w < `L1D_WAYS; w++) begin
			if (m_stat[w][a.index] != 2'd0 && m_tag[w][a.index] == a.tag) return w;
		end
		return -1;
	endfunction

	// Fill target is the same tag or the lowest way of the oldest status or way 3
	function automatic int pick_way(input l1d_addr_t a);
		for (int w = 0; w < `L1D_WAYS; w++) begin
			if (m_tag[w][a.index] == a.tag) return w;	// Status not looked at
		end
		for (int s = 0; s < 3; s++) begin
			for (int w = 0; w < `L1D_WAYS; w++) begin
				if (int'(m_stat[w][a.index]) == s) return w;
			end
		end
		return `L1D_WAYS - 1;
	endfunction

	// Expected read result from the model state before the edge
	function automatic l1d_rd_result_t predict_read(input logic req, input l1d_addr_t a);
		l1d_rd_result_t res;
		int w;
		w = find_way(a);
		res.valid = req;
		res.hit = req && w >= 0;
		res.data = (req && w >= 0) ? m_data[w][a.index][a.word_sel] : 32'h0;	// Zero on miss
		return res;
	endfunction

	task automatic step_model();
		logic aging;
		int rw;
		int sw;
		int fw;
		aging = &m_age;	// Last count of the period
		rw = find_way(rd_addr);
		sw = find_way(store.addr);
		fw = pick_way(fill.addr);
		if (!rd_stall) begin
			exp_q = predict_read(rd_req, rd_addr);
			m_age = m_age + 6'd1;
		end
		if (store_req) begin	// Store wins over fill
			if (sw >= 0) begin
				if (m_stat[sw][store.addr.index] != 2'd3) begin
					m_stat[sw][store.addr.index] = m_stat[sw][store.addr.index] + 2'd1;
				end
				for (int b = 0; b < 4; b++) begin
					if (store.mask[b]) begin
						m_data[sw][store.addr.index][store.addr.word_sel][8*b +: 8] =
							store.data[8*b +: 8];
					end
				end
			end
		end else if (fill_req) begin
			m_stat[fw][fill.addr.index] = 2'd3;
			m_tag[fw][fill.addr.index] = fill.addr.tag;
			for (int k = 0; k < `L1D_LINE_BYTES / 4; k++) begin
				m_data[fw][fill.addr.index][k] = fill.line.words[k];
			end
		end else if (!rd_stall) begin
			for (int w = 0; w < `L1D_WAYS; w++) begin
				for (int s = 0; s < `L1D_SETS; s++) begin
					if (rd_req && rw == w && int'(rd_addr.index) == s) begin
						m_stat[w][s] = 2'd3;	// Read hit refresh beats aging
					end else if (aging && m_stat[w][s] >= 2'd2) begin
						m_stat[w][s] = m_stat[w][s] - 2'd1;
					end
				end
			end
		end
	endtask

	always @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET || flush) begin
			for (int w = 0; w < `L1D_WAYS; w++) begin
				for (int s = 0; s < `L1D_SETS; s++) begin
					m_stat[w][s] = 2'd0;
					m_tag[w][s] = '0;
				end
			end
			m_age = '0;
			exp_q = '0;	// Pending read dropped
		end else begin
			step_model();
		end
	end

	// Outputs are settled by the falling edge
	always @(negedge iCLOCK) begin
		l1d_rd_result_t want;
		if (inRESET) begin
			want = exp_q;
			if (rd_stall) begin
				want = '0;	// Hidden while stalled
			end
			check_value("rd_result.valid", 32'(rd_result.valid), 32'(want.valid));
			check_value("rd_result.hit", 32'(rd_result.hit), 32'(want.hit));
			check_value("rd_result.data", rd_result.data, want.data);
			check_value("fill_busy", 32'(fill_busy), 32'(store_req));
			check_value("store_busy", 32'(store_busy), 32'(fill_req));
			check_value("rd_busy", 32'(rd_busy), 32'(rd_stall));
		end
	end

	function automatic l1d_addr_t addr_of(input logic [`L1D_TAG_W-1:0] t, input logic [3:0] i,
			input logic [3:0] w);
		return '{tag: t, index: i, word_sel: w, byte_off: 2'd0};
	endfunction

	function automatic l1d_line_t random_line();
		l1d_line_t l;
		for (int k = 0; k < `L1D_LINE_BYTES / 4; k++) begin
			l.words[k] = $random(seed);
		end
		return l;
	endfunction

	task automatic drive(input logic rq, input l1d_addr_t ra, input logic stall, input logic fq,
			input l1d_fill_t fl, input logic sq, input l1d_store_t st, input logic fs);
		@(posedge iCLOCK);
		rd_req <= rq;
		rd_addr <= ra;
		rd_stall <= stall;
		fill_req <= fq;
		fill <= fl;
		store_req <= sq;
		store <= st;
		flush <= fs;
	endtask

	task automatic read_word(input logic [`L1D_TAG_W-1:0] t, input logic [3:0] i,
			input logic [3:0] w);
		drive(1'b1, addr_of(t, i, w), 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
	endtask

	task automatic fill_line(input logic [`L1D_TAG_W-1:0] t, input logic [3:0] i);
		l1d_fill_t f;
		f.addr = addr_of(t, i, 4'd0);
		f.line = random_line();
		drive(1'b0, '0, 1'b0, 1'b1, f, 1'b0, '0, 1'b0);
	endtask

	task automatic store_word(input logic [`L1D_TAG_W-1:0] t, input logic [3:0] i,
			input logic [3:0] w, input logic [3:0] m, input logic [31:0] d);
		l1d_store_t s;
		s.addr = addr_of(t, i, w);
		s.mask = m;
		s.data = d;
		drive(1'b0, '0, 1'b0, 1'b0, '0, 1'b1, s, 1'b0);
	endtask

	task automatic wait_valid(input int limit);
		int n;
		n = 0;
		@(negedge iCLOCK);
		while (rd_result.valid !== 1'b1) begin
			if (n >= limit) begin
				$display("Timeout: no valid read result within %0d cycles", limit);
				$display("Test failed");
				$fatal(1, "timeout");
			end
			n++;
			@(negedge iCLOCK);
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [3:0] op;
		l1d_addr_t ra;
		l1d_addr_t wa;
		l1d_fill_t f;
		l1d_store_t s;
		seed = 32'h3a4e_1c15;
		inRESET = 1'b0;
		flush = 1'b0;
		rd_req = 1'b0;
		rd_stall = 1'b0;
		fill_req = 1'b0;
		store_req = 1'b0;
		rd_addr = '0;
		fill = '0;
		store = '0;
		repeat (5) @(posedge iCLOCK);
		inRESET <= 1'b1;

		// Whole line read back and two absent lines
		fill_line(22'h3a1, 4'd5);
		for (int k = 0; k < 16; k++) begin
			read_word(22'h3a1, 4'd5, 4'(k));
		end
		read_word(22'h3a2, 4'd5, 4'd0);
		read_word(22'h3a1, 4'd6, 4'd0);

		// Masked stores with about a quarter going to absent tag 2c6
		fill_line(22'h2c7, 4'd7);
		for (int k = 0; k < 12; k++) begin
			r = $random(seed);
			store_word(22'h2c7 ^ 22'(r[4] & r[5]), 4'd7, r[3:0], r[9:6], $random(seed));
			read_word(22'h2c7, 4'd7, r[3:0]);
		end
		f.addr = addr_of(22'h1e0, 4'd8, 4'd0);
		f.line = random_line();
		s.addr = addr_of(22'h2c7, 4'd7, 4'd2);
		s.mask = 4'hf;
		s.data = 32'h5a5a_0f0f;
		drive(1'b0, '0, 1'b0, 1'b1, f, 1'b1, s, 1'b0);	// Fill blocked by the store
		read_word(22'h1e0, 4'd8, 4'd0);
		read_word(22'h2c7, 4'd7, 4'd2);

		// Five tags into one set so the last fill evicts
		for (int k = 0; k < 5; k++) begin
			fill_line(22'h050 + 22'(k), 4'd3);
		end
		for (int k = 0; k < 5; k++) begin
			read_word(22'h050 + 22'(k), 4'd3, 4'd1);
		end

		// Held result across a stall
		read_word(22'h3a1, 4'd5, 4'd9);
		for (int k = 0; k < 3; k++) begin
			drive(1'b1, addr_of(22'h3a1, 4'd5, 4'(k)), 1'b1, 1'b0, '0, 1'b0, '0, 1'b0);
		end
		drive(1'b0, '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
		wait_valid(4);

		// Random mix on sets 8 to 11 over many aging periods
		for (int i = 0; i < 1500; i++) begin
			r = $random(seed);
			op = r[12:9];	// Op 0 and 1 fill, 2 to 4 store, 5 both and the rest read
			ra = addr_of(22'h100 + 22'(r[2:0]), {2'b10, r[4:3]}, r[8:5]);
			wa = addr_of(22'h100 + 22'(r[19:17]), {2'b10, r[21:20]}, r[25:22]);
			f.addr = wa;
			f.line = random_line();
			s.addr = wa;
			s.mask = r[16:13];
			s.data = $random(seed);
			drive(op > 4'd5 || (r[26] && ra.index != wa.index), ra, r[29:27] == 3'd0,
				op < 4'd2 || op == 4'd5, f, op >= 4'd2 && op <= 4'd5, s, 1'b0);
		end

		// Nothing survives a flush
		drive(1'b0, '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b1);
		for (int t = 0; t < 8; t++) begin
			for (int i = 8; i < 12; i++) begin
				read_word(22'h100 + 22'(t), 4'(i), 4'd0);
			end
		end
		read_word(22'h3a1, 4'd5, 4'd0);
		drive(1'b0, '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);
		wait_valid(4);
		drive(1'b0, '0, 1'b0, 1'b0, '0, 1'b0, '0, 1'b0);

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+logic
logic/l1d_pkg.sv
logic/l1d_tag_array.sv
logic/l1d_data_array.sv
logic/l1d_read_return.sv
logic/l1d_cache.sv
sim/tb_l1d_cache.sv
